//--- verilog.f
verilog/spi_init_pkg.sv
verilog/init_reg_table.sv
verilog/init_byte_pump.sv
verilog/init_sequencer.sv
verilog/spi_init_top.sv
dv/spi_init_sva.sv
dv/spi_init_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := spi_init_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/spi_init_tb.sv
`timescale 1ns/1ns

module spi_init_tb;
    import spi_init_pkg::*;

    ////////////////////////////////////////////////////////////
    // reference register list, send order, ls byte first
    ////////////////////////////////////////////////////////////

    localparam int N_REGS  = 11;
    localparam int N_BYTES = 44;                 // 5 + 6 + 9 + 8 x 3
    localparam int SEQ_LEN = N_BYTES + N_REGS;   // one queue entry per register

    localparam int         REG_LEN [N_REGS] = '{5, 6, 9, 3, 3, 3, 3, 3, 3, 3, 3};
    localparam logic [7:0] REG_DEV [N_REGS] = '{8'h01, 8'h01, 8'h01,          // dds
                                                8'h02, 8'h02, 8'h02, 8'h02,   // rsyn
                                                8'h03, 8'h03, 8'h03, 8'h03};  // msyn
    localparam logic [7:0] REF_BYTES [N_BYTES] = '{
        8'h00, 8'h40, 8'h00, 8'h00, 8'h00,                              // cfr1
        8'h00, 8'h90, 8'h49, 8'h02, 8'h00, 8'h01,                       // cfr2
        8'hea, 8'h3b, 8'h1b, 8'hf5, 8'h9d, 8'h0d, 8'h00, 8'h00, 8'h06,  // pcr0
        8'h13, 8'hf8, 8'h1f, 8'h12, 8'hf8, 8'h1f,                       // rsyn init, func
        8'h08, 8'h00, 8'h00, 8'h19, 8'h0b, 8'h00,                       // rsyn ref, div
        8'h13, 8'hf8, 8'h1f, 8'h12, 8'hf8, 8'h1f,                       // msyn init, func
        8'h04, 8'h00, 8'h00, 8'h0d, 8'h0a, 8'h00                        // msyn ref, div
    };

    localparam int unsigned SEED = 32'h067f_0dd3;
    localparam int ACK_MAX   = 3;    // fifo ack delay 0..3 cycles
    localparam int IDLE_LONG = 25;   // longest busy hold, idle_wait test
    // worst case of one run in cycles, then five runs with 2x margin
    localparam int RUN_CYCLES  = N_BYTES * (ACK_MAX + 1) + N_REGS * (ACK_MAX + IDLE_LONG + 6);
    localparam int WATCHDOG_NS = 8 * (2 * 5 * RUN_CYCLES + 200);

    logic      clk;
    logic      rst;
    logic      init_enable;
    logic      spi_proc_idle;
    logic      spi_wr_ack;
    logic      q_wr_ack;
    spi_byte_t spi_data;
    logic      spi_wr_en;
    dev_code_t q_data;
    logic      q_wr_en;
    logic      init_done;
    logic      init_busy;

    string      test_name;
    int         run_id;                    // bumped by the main process per run
    int         seen_run_id;
    int         run_pos, bytes_seen, q_seen, since_q, done_cnt;  // checker owned
    int         chk_errs, test_errs, errs_at_start, tests_run, tests_failed;
    int         idle_min, idle_max;        // processor busy hold range
    logic [8:0] run_log [$];               // {is_queue, value} per transfer
    logic [8:0] saved_log [$];

    spi_init_top uut (
        .clk                  (clk),
        .rst                  (rst),
        .init_enable_i        (init_enable),
        .spi_proc_idle_i      (spi_proc_idle),
        .spi_data_o           (spi_data),
        .spi_wr_en_o          (spi_wr_en),
        .spi_wr_ack_i         (spi_wr_ack),
        .spiwr_queue_data_o   (q_data),
        .spiwr_queue_wr_en_o  (q_wr_en),
        .spiwr_queue_wr_ack_i (q_wr_ack),
        .init_done_o          (init_done),
        .init_busy_o          (init_busy)
    );

    bind spi_init_top spi_init_sva u_sva (
        .clk                  (clk),
        .rst                  (rst),
        .spi_data_o           (spi_data_o),
        .spi_wr_en_o          (spi_wr_en_o),
        .spi_wr_ack_i         (spi_wr_ack_i),
        .spiwr_queue_data_o   (spiwr_queue_data_o),
        .spiwr_queue_wr_en_o  (spiwr_queue_wr_en_o),
        .spiwr_queue_wr_ack_i (spiwr_queue_wr_ack_i),
        .init_done_o          (init_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // transfer number pos of a full run, 9'h1ff past the end
    function automatic logic [8:0] expected_xfer(input int pos);
        int cur;
        int boff;   // first byte of register r in REF_BYTES
        cur  = 0;
        boff = 0;
        for (int r = 0; r < N_REGS; r++) begin
            if (pos < cur + REG_LEN[r]) begin
                return {1'b0, REF_BYTES[boff + pos - cur]};
            end
            cur = cur + REG_LEN[r];
            if (pos == cur) begin
                return {1'b1, REG_DEV[r]};     // queue entry after last byte
            end
            cur  = cur + 1;
            boff = boff + REG_LEN[r];
        end
        return 9'h1ff;
    endfunction

    function automatic int log_mismatches();
        int n;
        n = (run_log.size() == saved_log.size()) ? 0 : 1;
        foreach (run_log[i]) begin
            if (i < saved_log.size() && run_log[i] != saved_log[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // fifo and spi processor models
    ////////////////////////////////////////////////////////////

    // ack after a random wait, fresh draw per offered word
    task automatic draw_ack(input logic en, inout int left, output logic ack);
        if (!en) begin
            ack  = 1'b0;
            left = -1;
        end else begin
            if (left < 0) begin
                left = $urandom_range(ACK_MAX, 0);
            end
            ack  = (left == 0);
            left = left - 1;
        end
    endtask

    initial begin
        int data_left;
        int q_left;
        spi_wr_ack = 1'b0;
        q_wr_ack   = 1'b0;
        data_left  = -1;
        q_left     = -1;
        forever begin
            @(posedge clk);
            #1;
            draw_ack(spi_wr_en && !rst, data_left, spi_wr_ack);
            draw_ack(q_wr_en && !rst, q_left, q_wr_ack);
        end
    end

    // processor goes busy the cycle after a queue ack
    initial begin
        int hold;
        spi_proc_idle = 1'b1;
        forever begin
            @(negedge clk);
            if (q_wr_en && q_wr_ack) begin
                hold = $urandom_range(idle_max, idle_min);
                @(posedge clk);
                #1;
                spi_proc_idle = 1'b0;
                repeat (hold) @(posedge clk);
                #1;
                spi_proc_idle = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checker, samples mid cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [8:0] exp_x;
        logic [8:0] got_x;
        int         exp_len;
        if (run_id != seen_run_id) begin   // new run requested
            seen_run_id = run_id;
            run_pos     = 0;
            bytes_seen  = 0;
            q_seen      = 0;
            since_q     = 0;
            run_log.delete();
        end
        if (!rst) begin
            got_x = spi_wr_en ? {1'b0, spi_data} : {1'b1, q_data};
            if ((spi_wr_en && spi_wr_ack) || (q_wr_en && q_wr_ack)) begin
                exp_x = expected_xfer(run_pos);
                assert (got_x == exp_x) else begin
                    $display("[FAIL] %s: transfer %0d expected %h actual %h",
                             test_name, run_pos, exp_x, got_x);
                    chk_errs++;
                end
                run_log.push_back(got_x);
                run_pos++;
                if (!got_x[8]) begin
                    bytes_seen++;
                    since_q++;
                end else begin
                    exp_len = (q_seen < N_REGS) ? REG_LEN[q_seen] : 0;
                    assert (since_q == exp_len) else begin
                        $display("[FAIL] %s: bytes before queue write %0d expected %0d actual %0d",
                                 test_name, q_seen, exp_len, since_q);
                        chk_errs++;
                    end
                    since_q = 0;
                    q_seen++;
                end
            end
            assert (!(spi_wr_en && !spi_proc_idle)) else begin
                $display("error in %s: data byte offered while the processor is busy", test_name);
                chk_errs++;
            end
            // busy covers every write and the done pulse
            assert (init_busy || !(spi_wr_en || q_wr_en || init_done)) else begin
                $display("error in %s: write or done seen with init_busy_o low", test_name);
                chk_errs++;
            end
            if (init_done) begin
                done_cnt++;
                assert (run_pos == SEQ_LEN) else begin
                    $display("[FAIL] %s: transfers at done expected %0d actual %0d",
                             test_name, SEQ_LEN, run_pos);
                    chk_errs++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test steps
    ////////////////////////////////////////////////////////////

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = chk_errs + test_errs;
        tests_run++;
    endtask

    task automatic end_test();
        @(posedge clk);
        #1;
        if (chk_errs + test_errs == errs_at_start) begin
            $display("test %-14s ok", test_name);
        end else begin
            $display("test %-14s %0d errors", test_name, chk_errs + test_errs - errs_at_start);
            tests_failed++;
        end
    endtask

    // enable low for one cycle, then the run request
    task automatic start_run();
        init_enable = 1'b0;
        run_id++;
        @(posedge clk);
        #1;
        init_enable = 1'b1;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!init_done && n < 2 * RUN_CYCLES);
        if (!init_done) begin
            $display("error in %s: no init_done_o within %0d cycles", test_name, n);
            test_errs++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_count(input string what, input int exp_n, input int act_n);
        assert (exp_n == act_n) else begin
            $display("[FAIL] %s: %s expected %0d actual %0d", test_name, what, exp_n, act_n);
            test_errs++;
        end
    endtask

    initial begin
        int done_base;
        void'($urandom(SEED));
        rst         = 1'b1;
        init_enable = 1'b0;
        idle_min    = 2;
        idle_max    = 10;
        run_id      = 0;
        seen_run_id = 0;
        chk_errs    = 0;
        test_errs   = 0;
        done_cnt    = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("reset_quiet");
        repeat (20) begin
            @(negedge clk);
            assert (!spi_wr_en && !q_wr_en && !init_done && !init_busy) else begin
                $display("error in %s: output active with init_enable_i low", test_name);
                test_errs++;
            end
        end
        end_test();

        begin_test("byte_stream");
        start_run();
        wait_for_done();
        check_count("data bytes", N_BYTES, bytes_seen);
        saved_log = run_log;
        end_test();

        begin_test("queue_entries");
        start_run();
        wait_for_done();
        check_count("queue writes", N_REGS, q_seen);
        end_test();

        // longer busy holds stretch the run but keep its content
        begin_test("idle_wait");
        idle_min = IDLE_LONG - 10;
        idle_max = IDLE_LONG;
        start_run();
        wait_for_done();
        check_count("transfers", SEQ_LEN, run_pos);
        check_count("log mismatches", 0, log_mismatches());
        idle_min = 2;
        idle_max = 10;
        end_test();

        begin_test("done_restart");
        done_base = done_cnt;
        start_run();
        wait_for_done();
        saved_log = run_log;
        repeat (40) begin              // enable held high, no second run
            @(negedge clk);
            assert (!init_busy && !spi_wr_en && !q_wr_en) else begin
                $display("error in %s: new run started without enable going low", test_name);
                test_errs++;
            end
        end
        start_run();
        wait_for_done();
        check_count("done pulses", 2, done_cnt - done_base);
        check_count("log mismatches", 0, log_mismatches());
        end_test();

        $display("tests: %0d run, %0d failed, %0d errors",
                 tests_run, tests_failed, chk_errs + test_errs);
        if (chk_errs + test_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: simulation still running after %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- dv/spi_init_sva.sv
`timescale 1ns/1ns

module spi_init_sva (
    input logic                    clk,
    input logic                    rst,
    input spi_init_pkg::spi_byte_t spi_data_o,
    input logic                    spi_wr_en_o,
    input logic                    spi_wr_ack_i,
    input spi_init_pkg::dev_code_t spiwr_queue_data_o,
    input logic                    spiwr_queue_wr_en_o,
    input logic                    spiwr_queue_wr_ack_i,
    input logic                    init_done_o
);

    ////////////////////////////////////////////////////////////
    // fifo handshakes
    ////////////////////////////////////////////////////////////

    // byte stays on the data fifo port until the ack edge
    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        spi_wr_en_o && !spi_wr_ack_i |=> spi_wr_en_o && $stable(spi_data_o))
        else $error("data fifo write dropped or changed before its ack");

    // same rule on the write-request queue
    a_queue_hold: assert property (@(posedge clk) disable iff (rst)
        spiwr_queue_wr_en_o && !spiwr_queue_wr_ack_i
            |=> spiwr_queue_wr_en_o && $stable(spiwr_queue_data_o))
        else $error("queue write dropped or changed before its ack");

    ////////////////////////////////////////////////////////////
    // reset and done
    ////////////////////////////////////////////////////////////

    // covers every reset cycle and the first one after it
    a_quiet_reset: assert property (@(posedge clk)
        rst |=> !spi_wr_en_o && !spiwr_queue_wr_en_o)
        else $error("write enable high during or right after reset");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        init_done_o |=> !init_done_o)
        else $error("init_done_o longer than one cycle");

endmodule

//--- verilog/spi_init_top.sv
`timescale 1ns/1ns

module spi_init_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    init_enable_i,
    input  logic                    spi_proc_idle_i,
    // spi data fifo
    output spi_init_pkg::spi_byte_t spi_data_o,
    output logic                    spi_wr_en_o,
    input  logic                    spi_wr_ack_i,
    // spi write-request queue
    output spi_init_pkg::dev_code_t spiwr_queue_data_o,
    output logic                    spiwr_queue_wr_en_o,
    input  logic                    spiwr_queue_wr_ack_i,
    // to caller
    output logic                    init_done_o,
    output logic                    init_busy_o
);
    import spi_init_pkg::*;

    reg_idx_t  reg_idx;      // sequencer -> table
    byte_cnt_t byte_idx;     // pump -> table
    spi_byte_t tbl_byte;
    byte_cnt_t tbl_len;
    dev_code_t tbl_dev;
    logic      pump_start;
    logic      pump_done;

    init_sequencer u_seq (
        .clk                  (clk),
        .rst                  (rst),
        .init_enable_i        (init_enable_i),
        .spi_proc_idle_i      (spi_proc_idle_i),
        .pump_done_i          (pump_done),
        .dev_code_i           (tbl_dev),
        .spiwr_queue_wr_ack_i (spiwr_queue_wr_ack_i),
        .reg_idx_o            (reg_idx),
        .pump_start_o         (pump_start),
        .spiwr_queue_data_o   (spiwr_queue_data_o),
        .spiwr_queue_wr_en_o  (spiwr_queue_wr_en_o),
        .init_done_o          (init_done_o),
        .init_busy_o          (init_busy_o)
    );

    init_byte_pump u_pump (
        .clk          (clk),
        .rst          (rst),
        .start_i      (pump_start),
        .reg_len_i    (tbl_len),     // length straight from the table
        .byte_i       (tbl_byte),
        .spi_wr_ack_i (spi_wr_ack_i),
        .byte_idx_o   (byte_idx),
        .spi_data_o   (spi_data_o),
        .spi_wr_en_o  (spi_wr_en_o),
        .done_o       (pump_done)
    );

    init_reg_table u_table (
        .reg_idx_i  (reg_idx),
        .byte_idx_i (byte_idx),
        .byte_o     (tbl_byte),
        .reg_len_o  (tbl_len),
        .dev_code_o (tbl_dev)
    );

endmodule

//--- verilog/init_sequencer.sv
`timescale 1ns/1ns

module init_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    init_enable_i,         // level run request
    input  logic                    spi_proc_idle_i,
    input  logic                    pump_done_i,           // register bytes all in
    input  spi_init_pkg::dev_code_t dev_code_i,            // from table
    input  logic                    spiwr_queue_wr_ack_i,
    output spi_init_pkg::reg_idx_t  reg_idx_o,             // to table
    output logic                    pump_start_o,
    output spi_init_pkg::dev_code_t spiwr_queue_data_o,
    output logic                    spiwr_queue_wr_en_o,
    output logic                    init_done_o,
    output logic                    init_busy_o
);
    import spi_init_pkg::*;

    seq_state_t state;
    logic       en_seen_low;  // enable dropped since the last run began
    logic       last_reg;     // current register is the final one

    assign last_reg     = (reg_idx_o == reg_idx_t'(NUM_REGS - 1));
    assign pump_start_o = (state == SEQ_START);  // one cycle per register

    ////////////////////////////////////////////////////////////
    // register walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= SEQ_IDLE;
            reg_idx_o           <= '0;
            en_seen_low         <= 1'b1;   // first run after reset allowed
            spiwr_queue_wr_en_o <= 1'b0;
            init_done_o         <= 1'b0;
            init_busy_o         <= 1'b0;
        end else begin
            if (!init_enable_i) begin
                en_seen_low <= 1'b1;
            end
            case (state)
                SEQ_IDLE: begin
                    if (init_enable_i && spi_proc_idle_i && en_seen_low) begin
                        en_seen_low <= 1'b0;        // one run per enable
                        reg_idx_o   <= '0;
                        init_busy_o <= 1'b1;
                        state       <= SEQ_START;
                    end
                end
                SEQ_START: begin
                    state <= SEQ_PUMP;              // pump latches start this edge
                end
                SEQ_PUMP: begin
                    if (pump_done_i) begin
                        spiwr_queue_wr_en_o <= 1'b1;
                        state               <= SEQ_QUEUE;
                    end
                end
                SEQ_QUEUE: begin
                    if (spiwr_queue_wr_ack_i) begin
                        spiwr_queue_wr_en_o <= 1'b0;
                        state               <= SEQ_SETTLE;
                    end
                end
                SEQ_SETTLE: begin
                    // processor may still show idle here
                    state <= SEQ_WAIT_IDLE;
                end
                SEQ_WAIT_IDLE: begin
                    if (spi_proc_idle_i) begin
                        if (last_reg) begin
                            init_done_o <= 1'b1;
                            state       <= SEQ_DONE;
                        end else begin
                            reg_idx_o <= reg_idx_o + 4'd1;
                            state     <= SEQ_START;
                        end
                    end
                end
                SEQ_DONE: begin
                    init_done_o <= 1'b0;            // single cycle pulse
                    init_busy_o <= 1'b0;
                    state       <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // device code captured with the queue request, stable until acked
    always_ff @(posedge clk) begin
        if ((state == SEQ_PUMP) && pump_done_i) begin
            spiwr_queue_data_o <= dev_code_i;
        end
    end

endmodule

//--- verilog/init_byte_pump.sv
`timescale 1ns/1ns

module init_byte_pump (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,       // one cycle, from sequencer
    input  spi_init_pkg::byte_cnt_t reg_len_i,     // from table, valid with start
    input  spi_init_pkg::spi_byte_t byte_i,        // table byte at byte_idx_o
    input  logic                    spi_wr_ack_i,  // data fifo took the byte
    output spi_init_pkg::byte_cnt_t byte_idx_o,
    output spi_init_pkg::spi_byte_t spi_data_o,
    output logic                    spi_wr_en_o,
    output logic                    done_o         // one cycle after last ack
);
    import spi_init_pkg::*;

    pump_state_t state;
    byte_cnt_t   byte_idx;   // next byte to fetch, also count of bytes loaded
    byte_cnt_t   reg_len;    // latched length of the current register
    logic        load;       // put byte_i on the fifo port this edge
    logic        last_ack;   // final byte of the register accepted

    assign byte_idx_o = byte_idx;

    assign last_ack = (state == PUMP_WRITE) && spi_wr_ack_i && (byte_idx == reg_len);

    // start loads byte 0, every ack but the last loads the next one
    assign load = ((state == PUMP_IDLE) && start_i) ||
                  ((state == PUMP_WRITE) && spi_wr_ack_i && (byte_idx != reg_len));

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= PUMP_IDLE;
            byte_idx    <= '0;
            spi_wr_en_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            done_o <= 1'b0;  // strobe
            case (state)
                PUMP_IDLE: begin
                    if (start_i) begin
                        spi_wr_en_o <= 1'b1;           // byte 0 valid next cycle
                        byte_idx    <= byte_idx + 4'd1;
                        state       <= PUMP_WRITE;
                    end
                end
                PUMP_WRITE: begin
                    if (last_ack) begin
                        spi_wr_en_o <= 1'b0;
                        done_o      <= 1'b1;
                        byte_idx    <= '0;             // ready for the next register
                        state       <= PUMP_IDLE;
                    end else if (spi_wr_ack_i) begin
                        byte_idx <= byte_idx + 4'd1;   // enable stays up
                    end
                end
                default: begin
                    state <= PUMP_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            spi_data_o <= byte_i;     // held until acked
        end
        if ((state == PUMP_IDLE) && start_i) begin
            reg_len <= reg_len_i;
        end
    end

endmodule

//--- verilog/init_reg_table.sv
`timescale 1ns/1ns

module init_reg_table (
    input  spi_init_pkg::reg_idx_t  reg_idx_i,   // which register
    input  spi_init_pkg::byte_cnt_t byte_idx_i,  // which byte, 0 is ls byte
    output spi_init_pkg::spi_byte_t byte_o,
    output spi_init_pkg::byte_cnt_t reg_len_o,
    output spi_init_pkg::dev_code_t dev_code_o
);
    import spi_init_pkg::*;

    ////////////////////////////////////////////////////////////
    // register values, ls byte in bits 7:0
    ////////////////////////////////////////////////////////////

    // dds control and profile registers
    localparam logic [8*MAX_REG_BYTES-1:0] CFR1_VAL = 72'h00_0000_4000;
    localparam logic [8*MAX_REG_BYTES-1:0] CFR2_VAL = 72'h0100_0249_9000;
    localparam logic [8*MAX_REG_BYTES-1:0] PCR0_VAL = 72'h06_0000_0d9d_f51b_3bea;

    // synthesizer setup words, same layout for both parts
    localparam logic [8*MAX_REG_BYTES-1:0] SYN_INIT_VAL = 72'h1f_f813;  // init latch
    localparam logic [8*MAX_REG_BYTES-1:0] SYN_FUNC_VAL = 72'h1f_f812;  // function latch
    localparam logic [8*MAX_REG_BYTES-1:0] RSYN_REF_VAL = 72'h00_0008;  // r counter
    localparam logic [8*MAX_REG_BYTES-1:0] RSYN_DIV_VAL = 72'h00_0b19;  // n counter
    localparam logic [8*MAX_REG_BYTES-1:0] MSYN_REF_VAL = 72'h00_0004;
    localparam logic [8*MAX_REG_BYTES-1:0] MSYN_DIV_VAL = 72'h00_0a0d;

    logic [8*MAX_REG_BYTES-1:0] reg_val;  // selected register, zero padded

    // value lookup
    always_comb begin
        case (reg_idx_i)
            4'd0:    reg_val = CFR1_VAL;
            4'd1:    reg_val = CFR2_VAL;
            4'd2:    reg_val = PCR0_VAL;
            4'd3:    reg_val = SYN_INIT_VAL;
            4'd4:    reg_val = SYN_FUNC_VAL;
            4'd5:    reg_val = RSYN_REF_VAL;
            4'd6:    reg_val = RSYN_DIV_VAL;
            4'd7:    reg_val = SYN_INIT_VAL;
            4'd8:    reg_val = SYN_FUNC_VAL;
            4'd9:    reg_val = MSYN_REF_VAL;
            4'd10:   reg_val = MSYN_DIV_VAL;
            default: reg_val = '0;            // past the end of the list
        endcase
    end

    // length in bytes
    always_comb begin
        case (reg_idx_i)
            4'd0:    reg_len_o = 4'd5;   // cfr1
            4'd1:    reg_len_o = 4'd6;   // cfr2
            4'd2:    reg_len_o = 4'd9;   // pcr0
            default: reg_len_o = (reg_idx_i < reg_idx_t'(NUM_REGS)) ? 4'd3 : 4'd0;
        endcase
    end

    // device code by position in the list
    always_comb begin
        if (reg_idx_i < 4'd3) begin
            dev_code_o = DEV_DDS;
        end else if (reg_idx_i < 4'd7) begin
            dev_code_o = DEV_RSYN;
        end else begin
            dev_code_o = DEV_MSYN;
        end
    end

    // shift picks the byte, anything past the top reads as zero
    assign byte_o = spi_byte_t'(reg_val >> (8 * byte_idx_i));

endmodule

//--- verilog/spi_init_pkg.sv
package spi_init_pkg;

    ////////////////////////////////////////////////////////////
    // data widths on the spi side
    ////////////////////////////////////////////////////////////

    // one byte into the spi data fifo
    typedef logic [7:0] spi_byte_t;

    // device select written into the spi write-request queue
    typedef logic [7:0] dev_code_t;

    // position in the power-up register list, 0 to NUM_REGS-1
    typedef logic [3:0] reg_idx_t;

    // byte position inside a register, or a register length
    typedef logic [3:0] byte_cnt_t;

    ////////////////////////////////////////////////////////////
    // table sizes
    ////////////////////////////////////////////////////////////

    localparam int NUM_REGS      = 11;  // dds cfr1/cfr2/pcr0, 4 x rsyn, 4 x msyn
    localparam int MAX_REG_BYTES = 9;   // pcr0 is the long one

    ////////////////////////////////////////////////////////////
    // device codes seen by the spi processor
    ////////////////////////////////////////////////////////////

    localparam dev_code_t DEV_DDS  = 8'h01;  // direct digital synthesizer
    localparam dev_code_t DEV_RSYN = 8'h02;  // reference synthesizer
    localparam dev_code_t DEV_MSYN = 8'h03;  // main synthesizer

    ////////////////////////////////////////////////////////////
    // state machines
    ////////////////////////////////////////////////////////////

    // byte pump
    typedef enum logic [0:0] {
        PUMP_IDLE,      // waiting for a start strobe
        PUMP_WRITE      // a byte sits on the data fifo port
    } pump_state_t;

    // register sequencer
    typedef enum logic [2:0] {
        SEQ_IDLE,       // waiting for enable and processor idle
        SEQ_START,      // kick the byte pump for the current register
        SEQ_PUMP,       // bytes going into the data fifo
        SEQ_QUEUE,      // device code held on the queue port
        SEQ_SETTLE,     // one cycle for the processor to drop idle
        SEQ_WAIT_IDLE,  // spi transfer in flight
        SEQ_DONE        // done pulse cycle
    } seq_state_t;

endpackage
